// File: dtimLsu.f
+incdir+source
source/lsuPkg.sv
source/dtim.sv
source/subwordWrite.sv
source/subwordRead.sv
source/lrsc.sv
source/lsu.sv
verification/lsuClkRst.sv
verification/lsuTb.sv

// File: Bender.yml
package:
  name: dtimLsu

sources:
  - include_dirs:
      - source
    files:
      - source/lsuPkg.sv
      - source/dtim.sv
      - source/subwordWrite.sv
      - source/subwordRead.sv
      - source/lrsc.sv
      - source/lsu.sv
      - verification/lsuClkRst.sv
      - verification/lsuTb.sv

// File: verification/lsuTb.sv
`timescale 1ns/1ps
////////////////////////////////////////
// LSU testbench with E/M sequencing against a byte-lane memory model
////////////////////////////////////////
`include "lsu_config.svh"

module lsuTb;

  localparam lsuPkg::memRwT RD = 2'b10;
  localparam lsuPkg::memRwT WR = 2'b01;

  logic clk, arstN;
  lsuPkg::memRwT memRwE, memRwM;
  lsuPkg::wordT ieuAdrE, ieuAdrM, writeDataM, readDataW;
  lsuPkg::funct3T funct3M;
  lsuPkg::atomicT atomicM;
  logic bigEndianM, stallM, flushM, stallW;
  logic squashScW, loadMisalignedFaultM, storeMisalignedFaultM;

  lsuPkg::wordT modelMem [`LSU_DTIM_WORDS];  // Little-endian lanes as in the DTIM
  logic resValid;                            // Model reservation
  logic [`LSU_XLEN-3:0] resIdx;
  lsuPkg::wordT chkExp, lastLoad, expHold;
  logic chkValid;                            // Load in M and checked at the edge ending M
  integer seed;

  lsuClkRst clkRst (.clk(clk), .arstN(arstN));
  lsu DUT (.*);  // Port names match one to one

  task automatic reportFail(input string line);
    $display("%s", line);
    $display("TEST FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic logic isMisaligned(input lsuPkg::funct3T f3, input lsuPkg::wordT adr);
    if (f3[1:0] == lsuPkg::SIZE_HALF) return adr[0];
    if (f3[1:0] == lsuPkg::SIZE_WORD) return |adr[1:0];
    return 1'b0;  // Bytes never misaligned
  endfunction

  function automatic int sizeBytes(input lsuPkg::funct3T f3);
    return (f3[1:0] == lsuPkg::SIZE_BYTE) ? 1 : (f3[1:0] == lsuPkg::SIZE_HALF) ? 2 : 4;
  endfunction

  // Word index plus offset trimmed to the access size
  function automatic lsuPkg::wordT alignedAdr(input logic [7:0] idx, input logic [1:0] ofs,
                                              input lsuPkg::funct3T f3);
    logic [1:0] keep;
    keep = (f3[1:0] == lsuPkg::SIZE_BYTE) ? 2'b11 :
           (f3[1:0] == lsuPkg::SIZE_HALF) ? 2'b10 : 2'b00;
    return {22'd0, idx, ofs & keep};
  endfunction

  ////////////////////////////////////////
  // Reference model
  function automatic lsuPkg::wordT expectLoad(input lsuPkg::wordT adr, input lsuPkg::funct3T f3,
                                              input logic be);
    lsuPkg::wordT w;
    lsuPkg::wordT v;
    int n;
    w = modelMem[adr[`LSU_XLEN-1:2] % `LSU_DTIM_WORDS];
    n = sizeBytes(f3);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*(be ? n-1-i : i) +: 8] = w[8*(adr[1:0]+i) +: 8];  // Big endian reverses within size
    end
    if (!f3[2] && n < 4 && v[8*n-1]) begin
      v = v | ({`LSU_XLEN{1'b1}} << (8*n));  // Sign fill
    end
    return v;
  endfunction

  function automatic void storeModel(input lsuPkg::wordT adr, input lsuPkg::funct3T f3,
                                     input lsuPkg::wordT data, input logic be);
    int n;
    n = sizeBytes(f3);
    for (int i = 0; i < n; i++) begin
      modelMem[adr[`LSU_XLEN-1:2] % `LSU_DTIM_WORDS][8*(adr[1:0]+i) +: 8] =
        data[8*(be ? n-1-i : i) +: 8];
    end
  endfunction

  ////////////////////////////////////////
  // One access through E then M with inputs 2 ns after the edge
  task automatic access(input lsuPkg::memRwT rw, input lsuPkg::funct3T f3,
                        input lsuPkg::wordT adr, input lsuPkg::wordT data,
                        input logic be, input logic atom, input logic flush);
    logic misal;
    logic isSc;
    logic expSquash;
    misal = isMisaligned(f3, adr);
    isSc = atom & rw[0];
    expSquash = isSc & ~(resValid && resIdx == adr[`LSU_XLEN-1:2]);
    @(posedge clk);
    #2;
    memRwE = rw;
    ieuAdrE = adr;
    @(posedge clk);
    #2;
    memRwE = '0;
    memRwM = rw;
    funct3M = f3;
    atomicM = {1'b0, atom};
    writeDataM = data;
    bigEndianM = be;
    flushM = flush;
    if (rw[1] && !misal) begin
      chkExp = stallW ? lastLoad : expectLoad(adr, f3, be);  // Stall raised right after a load
      lastLoad = chkExp;
      chkValid = 1'b1;
    end
    #1;
    assert (loadMisalignedFaultM === (rw[1] & misal))
      else reportFail($sformatf("Fail at %0t ns: load fault flag wrong, adr %h", $time, adr));
    assert (storeMisalignedFaultM === (rw[0] & misal))
      else reportFail($sformatf("Fail at %0t ns: store fault flag wrong, adr %h", $time, adr));
    assert (ieuAdrM === adr)
      else reportFail($sformatf("Fail at %0t ns: ieuAdrM %h, expected %h", $time,
                                ieuAdrM, adr));
    @(posedge clk);
    #2;
    memRwM = '0;
    atomicM = '0;
    flushM = 1'b0;
    chkValid = 1'b0;
    if (!stallW) begin
      assert (squashScW === expSquash)
        else reportFail($sformatf("Fail at %0t ns: squashScW %b, expected %b", $time,
                                  squashScW, expSquash));
    end
    if (rw[0] && !misal && !flush && !expSquash) storeModel(adr, f3, data, be);
    if (!stallW && isSc) begin
      resValid = 1'b0;  // Any SC drops the reservation
    end else if (!stallW && atom && rw[1] && !misal && !flush) begin
      resValid = 1'b1;
      resIdx = adr[`LSU_XLEN-1:2];
    end
  endtask

  // Compare readDataW just after the edge that ends M
  always @(posedge clk) begin
    if (chkValid) begin
      expHold = chkExp;
      #1;
      assert (readDataW === expHold)
        else reportFail($sformatf("Fail at %0t ns: readDataW %h, expected %h", $time,
                                  readDataW, expHold));
    end
  end

  ////////////////////////////////////////
  // Stimulus
  initial begin
    lsuPkg::wordT adr;
    logic [31:0] r;
    lsuPkg::funct3T f3;
    int cnt;
    seed = 59;
    memRwE = '0;
    ieuAdrE = '0;
    memRwM = '0;
    funct3M = '0;
    atomicM = '0;
    writeDataM = '0;
    bigEndianM = 1'b0;
    stallM = 1'b0;
    flushM = 1'b0;
    stallW = 1'b0;
    resValid = 1'b0;
    chkValid = 1'b0;
    lastLoad = '0;
    cnt = 0;
    while (arstN !== 1'b1) begin
      @(posedge clk);
      cnt++;
      if (cnt > 10) reportFail("Reset was not released within 10 cycles");
    end
    // Fill every word then do random word loads
    for (int i = 0; i < `LSU_DTIM_WORDS; i++) access(WR, 3'b010, i*4, $random(seed), 0, 0, 0);
    for (int i = 0; i < 64; i++) begin
      r = $random(seed);
      access(RD, 3'b010, {22'd0, r[7:0], 2'b00}, '0, 0, 0, 0);
    end
    // Sub-word stores and loads in little then big endian
    for (int k = 0; k < 80; k++) begin
      r = $random(seed);
      f3 = (r[18:17] == 2'b11) ? 3'b010 : {2'b00, r[0]};  // Byte, half or word store
      access(WR, f3, alignedAdr(r[9:2], r[11:10], f3), $random(seed), k >= 40, 0, 0);
      f3 = (r[14:13] == 2'b11 || r[14:13] == 2'b10) ? 3'b010 : {r[12], r[14:13]};
      access(RD, f3, alignedAdr(r[9:2], r[16:15], f3), '0, k >= 40, 0, 0);
    end
    // Misaligned accesses leave memory unchanged
    for (int k = 0; k < 12; k++) begin
      r = $random(seed);
      f3 = r[0] ? 3'b001 : 3'b010;
      adr = {22'd0, r[9:2], r[0] ? {r[10], 1'b1} : ((r[11:10] == 2'b00) ? 2'b11 : r[11:10])};
      access(WR, f3, adr, $random(seed), r[12], 0, 0);
      access(RD, f3, adr, '0, 0, 0, 0);
      access(RD, 3'b010, {adr[31:2], 2'b00}, '0, 0, 0, 0);
    end
    // LR/SC pass plus SC without reservation and SC to another word
    access(RD, 3'b010, 32'h40, '0, 0, 1, 0);
    access(WR, 3'b010, 32'h40, 32'hCAFE_0001, 0, 1, 0);
    access(RD, 3'b010, 32'h40, '0, 0, 0, 0);
    access(WR, 3'b010, 32'h40, 32'hCAFE_0002, 0, 1, 0);
    access(RD, 3'b010, 32'h40, '0, 0, 0, 0);
    access(RD, 3'b010, 32'h40, '0, 0, 1, 0);
    access(WR, 3'b010, 32'h80, 32'hCAFE_0003, 0, 1, 0);
    access(RD, 3'b010, 32'h80, '0, 0, 0, 0);
    // Flushed store then a W stall that holds the last load
    access(WR, 3'b010, 32'h10, 32'h1234_5678, 0, 0, 1);
    access(RD, 3'b010, 32'h10, '0, 0, 0, 0);
    stallW = 1'b1;
    access(RD, 3'b001, 32'h22, '0, 0, 0, 0);
    stallW = 1'b0;
    access(RD, 3'b001, 32'h22, '0, 0, 0, 0);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: verification/lsuClkRst.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////
module lsuClkRst (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    arstN = 1'b0;
    repeat (3) @(posedge clk);
    #2 arstN = 1'b1;  // Released after three cycles
  end

endmodule

// File: source/lsu.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Load/store unit top level
// E-to-M address, DTIM access, sub-word paths, LR/SC
////////////////////////////////////////
module lsu (
  input  logic           clk,
  input  logic           arstN,
  input  lsuPkg::memRwT  memRwE,                // Execute access code
  input  lsuPkg::wordT   ieuAdrE,               // Execute address
  input  lsuPkg::memRwT  memRwM,                // Memory access code
  input  lsuPkg::funct3T funct3M,               // Size and sign
  input  lsuPkg::atomicT atomicM,               // LR/SC flag in low bit
  input  lsuPkg::wordT   writeDataM,            // Store data from IEU
  input  logic           bigEndianM,            // Big-endian mode
  input  logic           stallM,
  input  logic           flushM,
  input  logic           stallW,
  output lsuPkg::wordT   ieuAdrM,               // Memory stage address
  output lsuPkg::wordT   readDataW,             // Load result
  output logic           squashScW,             // SC failed
  output logic           loadMisalignedFaultM,
  output logic           storeMisalignedFaultM
);

  lsuPkg::wordT     laneDataM;       // Replicated, swapped store data
  lsuPkg::byteMaskT byteMaskM;       // Lanes written
  lsuPkg::wordT     readWordM;       // Raw DTIM word
  lsuPkg::wordT     readDataM;       // Extracted load value
  lsuPkg::memRwT    memRwLsuM;       // Access code after SC gating
  logic             squashScM;
  logic             misalignedAdrM;  // Address not aligned to size
  logic             dtimReadEn;
  logic             dtimWriteEn;

  ////////////////////////////////////////
  // E to M address register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ieuAdrM <= '0;
    end else if (!stallM) begin
      ieuAdrM <= ieuAdrE;
    end
  end

  ////////////////////////////////////////
  // Misalignment check
  always_comb begin
    case (funct3M[1:0])
      lsuPkg::SIZE_HALF: misalignedAdrM = ieuAdrM[0];
      lsuPkg::SIZE_WORD: misalignedAdrM = |ieuAdrM[1:0];
      default:           misalignedAdrM = 1'b0;  // Bytes always aligned
    endcase
  end

  assign loadMisalignedFaultM  = memRwM[lsuPkg::RW_READ_BIT] & misalignedAdrM;
  assign storeMisalignedFaultM = memRwM[lsuPkg::RW_WRITE_BIT] & misalignedAdrM;

  // Store path
  subwordWrite subwordWrite (
    .funct3    (funct3M),
    .adrLow    (ieuAdrM[1:0]),
    .writeData (writeDataM),
    .bigEndian (bigEndianM),
    .laneData  (laneDataM),
    .byteMask  (byteMaskM)
  );

  lrsc lrsc (
    .clk      (clk),
    .arstN    (arstN),
    .stallW   (stallW),
    .memRwM   (memRwM),
    .atomicM  (atomicM),
    .adrM     (ieuAdrM),
    .suppress (loadMisalignedFaultM | storeMisalignedFaultM | flushM),
    .memRwOut (memRwLsuM),
    .squashSc (squashScM)
  );

  // Read issued from E, write retired at end of M
  assign dtimReadEn  = memRwE[lsuPkg::RW_READ_BIT] & ~stallM;
  assign dtimWriteEn = memRwLsuM[lsuPkg::RW_WRITE_BIT] & ~flushM
                     & ~storeMisalignedFaultM & ~stallM;

  dtim dtim (
    .clk       (clk),
    .readEn    (dtimReadEn),
    .readAdr   (ieuAdrE),
    .writeEn   (dtimWriteEn),
    .writeAdr  (ieuAdrM),
    .writeData (laneDataM),
    .byteMask  (byteMaskM),
    .readData  (readWordM)
  );

  // Load path
  subwordRead subwordRead (
    .readWord  (readWordM),
    .adrLow    (ieuAdrM[1:0]),
    .funct3    (funct3M),
    .bigEndian (bigEndianM),
    .readData  (readDataM)
  );

  ////////////////////////////////////////
  // M to W registers
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      readDataW <= '0;
      squashScW <= 1'b0;
    end else if (!stallW) begin
      readDataW <= readDataM;
      squashScW <= squashScM;
    end
  end

endmodule

// File: source/lrsc.sv
`timescale 1ns/1ps
////////////////////////////////////////
// LR/SC reservation tracker
// Gates failed SC writes, flags the squash
////////////////////////////////////////
module lrsc (
  input  logic           clk,
  input  logic           arstN,
  input  logic           stallW,     // Holds reservation state
  input  lsuPkg::memRwT  memRwM,
  input  lsuPkg::atomicT atomicM,
  input  lsuPkg::wordT   adrM,       // Memory stage address
  input  logic           suppress,   // Faulted or flushed access
  output lsuPkg::memRwT  memRwOut,   // Access code, SC write gated
  output logic           squashSc    // SC failed this cycle
);

  logic                          resValid;  // Reservation held
  logic [$bits(lsuPkg::wordT)-1:2] resAdr;  // Reserved word address
  logic                          isLr;
  logic                          isSc;
  logic                          scPass;

  assign isLr = atomicM[lsuPkg::ATOMIC_LRSC_BIT] & memRwM[lsuPkg::RW_READ_BIT];
  assign isSc = atomicM[lsuPkg::ATOMIC_LRSC_BIT] & memRwM[lsuPkg::RW_WRITE_BIT];

  assign scPass   = resValid & (resAdr == adrM[$bits(lsuPkg::wordT)-1:2]);  // Same word
  assign squashSc = isSc & ~scPass;

  // Failed SC loses its write strobe
  assign memRwOut = {memRwM[lsuPkg::RW_READ_BIT], memRwM[lsuPkg::RW_WRITE_BIT] & ~squashSc};

  ////////////////////////////////////////
  // Reservation state
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
    end else if (!stallW) begin
      if (isSc) begin
        resValid <= 1'b0;  // Any SC ends the reservation
      end else if (isLr && !suppress) begin
        resValid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stallW && isLr && !suppress) begin
      resAdr <= adrM[$bits(lsuPkg::wordT)-1:2];
    end
  end

endmodule

// File: source/subwordRead.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Load extraction
// Endian swap, lane select, sign or zero extend
////////////////////////////////////////
`include "lsu_config.svh"

module subwordRead (
  input  lsuPkg::wordT   readWord,   // Raw DTIM word
  input  logic [1:0]     adrLow,     // Byte offset in word
  input  lsuPkg::funct3T funct3,     // Size and unsigned flag
  input  logic           bigEndian,
  output lsuPkg::wordT   readData    // Extended load value
);

  lsuPkg::wordT swapped;    // Word in little-endian order
  logic [1:0]   laneOfs;    // Offset after the swap
  logic [7:0]   byteVal;
  logic [15:0]  halfVal;
  logic         signBit;
  logic         isSigned;

  ////////////////////////////////////////
  // Byte swap
  assign swapped = bigEndian ? lsuPkg::swapBytes(readWord) : readWord;

  // Swap mirrors the lanes, so mirror the offset too
  assign laneOfs = adrLow ^ {2{bigEndian}};

  // Lane select
  assign byteVal = swapped[8*laneOfs +: 8];
  assign halfVal = swapped[16*laneOfs[1] +: 16];

  assign isSigned = ~funct3[2];  // Top bit means unsigned

  ////////////////////////////////////////
  // Extension
  always_comb begin
    signBit = 1'b0;
    case (funct3[1:0])
      lsuPkg::SIZE_BYTE: begin
        signBit  = isSigned & byteVal[7];
        readData = {{(`LSU_XLEN-8){signBit}}, byteVal};
      end
      lsuPkg::SIZE_HALF: begin
        signBit  = isSigned & halfVal[15];
        readData = {{(`LSU_XLEN-16){signBit}}, halfVal};
      end
      default: begin
        readData = swapped;  // Word load
      end
    endcase
  end

endmodule

// File: source/subwordWrite.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Store preparation
// Size replication, byte mask, endian swap
////////////////////////////////////////
module subwordWrite (
  input  lsuPkg::funct3T   funct3,     // Access size
  input  logic [1:0]       adrLow,     // Byte offset in word
  input  lsuPkg::wordT     writeData,  // Store data, low aligned
  input  logic             bigEndian,
  output lsuPkg::wordT     laneData,   // Data placed on all lanes
  output lsuPkg::byteMaskT byteMask    // Lanes to write
);

  lsuPkg::wordT replicated;  // Little-endian replicated data

  ////////////////////////////////////////
  // Replicate across the word
  always_comb begin
    case (funct3[1:0])
      lsuPkg::SIZE_BYTE: begin
        replicated = {($bits(lsuPkg::wordT)/8){writeData[7:0]}};
      end
      lsuPkg::SIZE_HALF: begin
        replicated = {($bits(lsuPkg::wordT)/16){writeData[15:0]}};
      end
      default: begin
        replicated = writeData;  // Full word
      end
    endcase
  end

  // Whole-word swap keeps lanes tied to the address offset
  assign laneData = bigEndian ? lsuPkg::swapBytes(replicated) : replicated;

  ////////////////////////////////////////
  // Byte mask from size and offset
  always_comb begin
    case (funct3[1:0])
      lsuPkg::SIZE_BYTE: begin
        byteMask = lsuPkg::byteMaskT'(1) << adrLow;
      end
      lsuPkg::SIZE_HALF: begin
        byteMask = lsuPkg::byteMaskT'(3) << {adrLow[1], 1'b0};  // Half-word pair
      end
      lsuPkg::SIZE_WORD: begin
        byteMask = '1;
      end
      default: begin
        byteMask = '0;  // Doubleword not supported
      end
    endcase
  end

endmodule

// File: source/dtim.sv
`timescale 1ns/1ps
////////////////////////////////////////
// Data tightly integrated memory
// Word wide, registered read, byte-masked write
////////////////////////////////////////
`include "lsu_config.svh"

module dtim #(
  parameter int WORDS = `LSU_DTIM_WORDS  // Depth, power of two
) (
  input  logic             clk,
  input  logic             readEn,     // Capture read word
  input  lsuPkg::wordT     readAdr,    // Byte address, E stage
  input  logic             writeEn,
  input  lsuPkg::wordT     writeAdr,   // Byte address, M stage
  input  lsuPkg::wordT     writeData,  // Lane-aligned data
  input  lsuPkg::byteMaskT byteMask,
  output lsuPkg::wordT     readData
);

  localparam int ADR_BITS = $clog2(WORDS);
  localparam int LANES    = $bits(lsuPkg::byteMaskT);

  lsuPkg::wordT        mem [WORDS];
  logic [ADR_BITS-1:0] readIdx;   // Word index
  logic [ADR_BITS-1:0] writeIdx;

  // Drop the byte offset bits
  assign readIdx  = readAdr[ADR_BITS+1:2];
  assign writeIdx = writeAdr[ADR_BITS+1:2];

  ////////////////////////////////////////
  // Write port
  always_ff @(posedge clk) begin
    if (writeEn) begin
      for (int i = 0; i < LANES; i++) begin
        if (byteMask[i]) begin
          mem[writeIdx][8*i +: 8] <= writeData[8*i +: 8];  // Masked lane only
        end
      end
    end
  end

  // Read port, old data on same-cycle write
  always_ff @(posedge clk) begin
    if (readEn) begin
      readData <= mem[readIdx];
    end
  end

endmodule

// File: source/lsuPkg.sv
////////////////////////////////////////
// LSU shared types and encodings
// Access size, read/write code, byte swap
////////////////////////////////////////
`include "lsu_config.svh"

package lsuPkg;

  typedef logic [`LSU_XLEN-1:0]   wordT;      // Data or address word
  typedef logic [`LSU_XLEN/8-1:0] byteMaskT;  // One bit per byte lane
  typedef logic [1:0]             memRwT;     // {read, write}, 00 is idle
  typedef logic [2:0]             funct3T;    // {unsigned, size[1:0]}
  typedef logic [1:0]             atomicT;    // {amo, lrsc}, amo unused

  localparam int RW_READ_BIT     = 1;  // Read strobe in memRwT
  localparam int RW_WRITE_BIT    = 0;  // Write strobe in memRwT
  localparam int ATOMIC_LRSC_BIT = 0;  // LR/SC flag in atomicT

  // Low two bits of funct3, RISC-V load/store order
  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;

  // Reverse byte order of a word
  function automatic wordT swapBytes(input wordT a);
    wordT y;
    for (int i = 0; i < $bits(wordT) / 8; i++) begin
      y[8*i +: 8] = a[$bits(wordT) - 8*(i+1) +: 8];  // Lane i takes mirrored lane
    end
    return y;
  endfunction

endpackage

// File: source/lsu_config.svh
////////////////////////////////////////
// LSU configuration
// Data width and DTIM depth
////////////////////////////////////////
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width
`define LSU_XLEN 32

// DTIM depth in words, power of two
`define LSU_DTIM_WORDS 256

`endif
